// ==== hw/video_bypass_pkg.sv ====
// Shared constants, register addresses and bus/state structs for the LCD timing bypass
package video_bypass_pkg;

    // Frame geometry defaults, in line ticks (4 ce each) and lines
    localparam int LINE_TICKS    = 114;
    localparam int FRAME_LINES   = 154;
    localparam int VISIBLE_LINES = 144;

    // OAM search length and last pixel slot (0-7 prefetch, 8-167 visible)
    localparam int OAM_TICKS = 20;
    localparam int PIXEL_END = 168;

    // CPU register addresses, low byte of 0xFFxx
    localparam logic [7:0] REG_LCDC = 8'h40;
    localparam logic [7:0] REG_SCX  = 8'h43;
    localparam logic [7:0] REG_BGPI = 8'h68;
    localparam logic [7:0] REG_BGPD = 8'h69;

    // STAT mode codes
    localparam logic [1:0] MODE_HBLANK = 2'd0;
    localparam logic [1:0] MODE_VBLANK = 2'd1;
    localparam logic [1:0] MODE_OAM    = 2'd2;
    localparam logic [1:0] MODE_DRAW   = 2'd3;

    // One CPU register write request
    typedef struct packed {
        logic       sel_reg;
        logic       wr;
        logic [7:0] addr;
        logic [7:0] data;
    } cpu_bus_t;

    // Register state used by the timing stages
    typedef struct packed {
        logic       lcd_enable;
        logic [2:0] scx_fine;
    } lcd_cfg_t;

    // Per-line timing handed from line_timing to pixel_timing
    typedef struct packed {
        logic       h_clk_en;
        logic       h_clk_en_neg;
        logic [6:0] line_tick;
        logic       end_of_line;
        logic       vblank_raw;
        logic       vblank_l;
        logic       vblank_t;
    } line_state_t;

endpackage

// ==== hw/lcd_regs.sv ====
// CPU register writes for LCDC, SCX and the colour background palette, feeding the timing chain
`timescale 1ns/1ps

module lcd_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ce_cpu,
    input  logic                       is_gbc,
    input  logic                       is_gbc_mode,
    input  logic                       drawing,
    input  video_bypass_pkg::cpu_bus_t cpu,
    output video_bypass_pkg::lcd_cfg_t cfg,
    output logic [7:0]                 pal_lo,
    output logic [7:0]                 pal_hi
);
    import video_bypass_pkg::*;

    logic       wr_en;
    logic       pal_wr;
    logic [5:0] bgpi;
    logic       bgpi_ai;

    // Qualified register write strobe
    assign wr_en = ce_cpu && cpu.sel_reg && cpu.wr;

    // Palette data write, colour mode only
    assign pal_wr = wr_en && is_gbc && is_gbc_mode && (cpu.addr == REG_BGPD);

    // --------------------
    // Control registers
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg     <= '0;
            bgpi    <= 6'd0;
            bgpi_ai <= 1'b0;
        end else if (wr_en) begin
            case (cpu.addr)
                REG_LCDC: cfg.lcd_enable <= cpu.data[7];
                REG_SCX:  cfg.scx_fine   <= cpu.data[2:0];
                REG_BGPI: begin
                    // Index register exists on colour hardware only
                    if (is_gbc) begin
                        bgpi    <= cpu.data[5:0];
                        bgpi_ai <= cpu.data[7];
                    end
                end
                default: ;
            endcase
            // Index still advances when the data write is blocked by mode 3
            if (pal_wr && bgpi_ai) begin
                bgpi <= bgpi + 6'd1;
            end
        end
    end

    // --------------------
    // Palette bytes 0 and 1, the only ones the output reads
    always_ff @(posedge clk) begin
        if (pal_wr && !drawing) begin
            if (bgpi == 6'd0) begin
                pal_lo <= cpu.data;
            end
            if (bgpi == 6'd1) begin
                pal_hi <= cpu.data;
            end
        end
    end

endmodule

// ==== hw/lcd_restart.sv ====
// LCD restart FSM that holds the bypass in front until the real video unit is back in step
`timescale 1ns/1ps

module lcd_restart (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ce,
    input  video_bypass_pkg::lcd_cfg_t cfg,
    input  logic                       lcd_vsync,
    input  logic [1:0]                 mode_real,
    output logic                       lcd_on,
    output logic                       restart,
    output logic                       overwrite,
    output logic                       vsync_overwrite
);

    typedef enum logic [2:0] {
        ST_OFF             = 3'd0,
        ST_WAIT_VSYNC      = 3'd1,
        ST_WAIT_VSYNC_REAL = 3'd2,
        ST_WAIT_START_REAL = 3'd3,
        ST_WAIT_CE         = 3'd4,
        ST_WAIT_VSYNC_END  = 3'd5
    } state_t;

    state_t     state;
    logic       enable_l;
    logic [3:0] ce_cnt;
    logic       real_wait;

    // Both states where the real unit is being waited on
    assign real_wait = (state == ST_WAIT_VSYNC_REAL) || (state == ST_WAIT_START_REAL);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_OFF;
            enable_l <= 1'b0;
            ce_cnt   <= 4'd0;
            restart  <= 1'b0;
        end else begin
            // Enable copy and free-running counter step on ce
            if (ce) begin
                enable_l <= cfg.lcd_enable;
                ce_cnt   <= ce_cnt + 4'd1;
            end
            case (state)
                // Rising edge of LCDC bit 7
                ST_OFF: if (cfg.lcd_enable && !enable_l) state <= ST_WAIT_VSYNC;
                ST_WAIT_VSYNC: begin
                    if (lcd_vsync) begin
                        state   <= ST_WAIT_VSYNC_REAL;
                        restart <= 1'b1;
                    end
                end
                // Real unit reports vblank
                ST_WAIT_VSYNC_REAL: if (mode_real == 2'd1) state <= ST_WAIT_START_REAL;
                // Real unit starts OAM search
                ST_WAIT_START_REAL: if (ce && mode_real == 2'd2) state <= ST_WAIT_CE;
                ST_WAIT_CE: begin
                    if (ce) begin
                        state   <= ST_WAIT_VSYNC_END;
                        restart <= 1'b0;
                    end
                end
                ST_WAIT_VSYNC_END: if (mode_real == 2'd0) state <= ST_OFF;
                default: state <= ST_OFF;
            endcase
        end
    end

    // Output levels by state
    assign overwrite       = (state != ST_OFF);
    assign vsync_overwrite = real_wait;
    assign lcd_on          = !(real_wait && (ce_cnt != 4'd0));

endmodule

// ==== hw/line_timing.sv ====
// Dot divider, line tick and line counters with vblank latching and vsync for the bypass timing
`timescale 1ns/1ps

module line_timing #(
    parameter int LINE_TICKS    = video_bypass_pkg::LINE_TICKS,
    parameter int FRAME_LINES   = video_bypass_pkg::FRAME_LINES,
    parameter int VISIBLE_LINES = video_bypass_pkg::VISIBLE_LINES
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ce,
    input  logic                          is_gbc,
    input  logic                          lcd_on,
    input  logic                          restart,
    output video_bypass_pkg::line_state_t line,
    output logic                          lcd_vsync
);

    logic [1:0] h_div_cnt;
    logic [6:0] h_cnt;
    logic [7:0] v_cnt;
    logic       h_clk_en;
    logic       h_clk_en_neg;
    logic       hcnt_end;
    logic       line_last;
    logic       vblank_raw;
    logic       wrap_phase;
    logic       end_of_line;
    logic       vblank_t;
    logic       vblank_l;
    logic       vcnt_eol_l;
    logic       vcnt_reset;

    // Tick phases 0 and 2 of the divide-by-four
    assign h_clk_en     = lcd_on && (h_div_cnt == 2'd0);
    assign h_clk_en_neg = lcd_on && (h_div_cnt == 2'd2);
    assign hcnt_end     = (h_cnt == 7'(LINE_TICKS - 1));
    assign line_last    = (v_cnt == 8'(FRAME_LINES - 1));
    assign vblank_raw   = (v_cnt >= 8'(VISIBLE_LINES));

    // Colour hardware wraps the last line one phase later
    assign wrap_phase = is_gbc ? h_clk_en_neg : h_clk_en;

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            h_div_cnt   <= 2'd0;
            h_cnt       <= 7'd0;
            v_cnt       <= 8'd0;
            end_of_line <= 1'b0;
            vblank_t    <= 1'b0;
            vblank_l    <= 1'b0;
            vcnt_eol_l  <= 1'b0;
            vcnt_reset  <= 1'b0;
            lcd_vsync   <= 1'b0;
        end else if (ce) begin
            h_div_cnt <= h_div_cnt + 2'd1;
            if (h_clk_en) begin
                h_cnt <= hcnt_end ? 7'd0 : h_cnt + 7'd1;
            end

            // --------------------
            // End of line pulse, four ce long
            vblank_l <= vblank_t;
            if (h_clk_en_neg && hcnt_end) begin
                end_of_line <= 1'b1;
            end else if (end_of_line) begin
                // Vblank is taken a few cycles after line end
                if (h_clk_en) vblank_t <= vblank_raw;
                if (h_clk_en_neg) end_of_line <= 1'b0;
            end

            // --------------------
            // Line counter, held while the wrap is in effect
            if (!vcnt_reset && h_clk_en_neg && hcnt_end) begin
                v_cnt <= v_cnt + 8'd1;
            end
            if (wrap_phase) begin
                vcnt_eol_l <= end_of_line;
                if (vcnt_eol_l && !end_of_line) begin
                    // Last line drops to 0 early, so line 0 lasts almost two lines
                    vcnt_reset <= line_last;
                    if (line_last) v_cnt <= 8'd0;
                    lcd_vsync <= (v_cnt == 8'd0);
                end
            end
        end
    end

    always_comb begin
        line.h_clk_en     = h_clk_en;
        line.h_clk_en_neg = h_clk_en_neg;
        line.line_tick    = h_cnt;
        line.end_of_line  = end_of_line;
        line.vblank_raw   = vblank_raw;
        line.vblank_l     = vblank_l;
        line.vblank_t     = vblank_t;
    end

endmodule

// ==== hw/pixel_timing.sv ====
// Pixel slot timing with fine-scroll skip and background fetch cadence, giving mode and LCD strobe
`timescale 1ns/1ps

module pixel_timing #(
    parameter int LINE_TICKS = video_bypass_pkg::LINE_TICKS
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ce,
    input  logic                          is_gbc,
    input  logic                          lcd_on,
    input  logic                          restart,
    input  video_bypass_pkg::line_state_t line,
    input  logic [2:0]                    scx_fine,
    output logic [1:0]                    mode,
    output logic                          lcd_clkena,
    output logic                          drawing
);
    import video_bypass_pkg::*;

    logic [7:0] pcnt;
    logic [2:0] skip_cnt;
    logic       skip_done;
    logic [2:0] bg_fetch_cycle;
    logic [3:0] bg_shift_cnt;
    logic       mode3_end_l;
    logic       mode3_l;
    logic       oam_eval_l;
    logic       skip_end;
    logic       skip_en;
    logic       pcnt_end;
    logic       pcnt_reset;
    logic       line_last;
    logic       bg_fetch_done;
    logic       bg_shift_empty;
    logic       bg_reload_shift;
    logic       oam_eval;
    logic       mode3;
    logic       mode3_end;
    logic       lcd_clk;
    logic       mode_vblank;

    // Skip scx_fine slots at the start of the line
    assign skip_end = (skip_cnt == scx_fine) || (&skip_cnt);
    assign skip_en  = !skip_done && !skip_end;

    assign pcnt_end   = (pcnt == 8'(PIXEL_END));
    assign pcnt_reset = line.h_clk_en && line.end_of_line && !line.vblank_raw;
    assign line_last  = (line.line_tick == 7'(LINE_TICKS - 1));

    // Fetch takes six ce; reload when the shifter is nearly empty
    assign bg_fetch_done   = (bg_fetch_cycle >= 3'd5);
    assign bg_shift_empty  = (bg_shift_cnt == 4'd0);
    assign bg_reload_shift = (bg_shift_cnt <= 4'd1);

    // OAM search is the first ticks of each visible line
    assign oam_eval = lcd_on && !line.vblank_t && (line.line_tick < 7'(OAM_TICKS));
    assign mode3    = lcd_on && !oam_eval && !mode3_end_l;

    // Last visible pixel, also forced at line end so mode 3 never crosses it
    assign mode3_end = (lcd_clk && pcnt == 8'(PIXEL_END - 1)) || pcnt_end || line_last;

    // Slots 0-7 are offscreen prefetch
    assign lcd_clk = mode3 && !skip_en && !bg_shift_empty && (pcnt >= 8'd8);

    // --------------------
    // Pixel, skip and fetch counters
    always_ff @(posedge clk) begin
        if (reset || restart || (ce && pcnt_reset)) begin
            pcnt           <= 8'd0;
            skip_cnt       <= 3'd0;
            skip_done      <= 1'b0;
            bg_fetch_cycle <= 3'd0;
            bg_shift_cnt   <= 4'd0;
        end else if (ce && mode3) begin
            if (!bg_shift_empty) begin
                if (!skip_done) begin
                    if (!skip_end) skip_cnt <= skip_cnt + 3'd1;
                    else skip_done <= 1'b1;
                end
                if (!skip_en && !pcnt_end) pcnt <= pcnt + 8'd1;
                bg_shift_cnt <= bg_shift_cnt - 4'd1;
            end
            if (!(&bg_fetch_cycle)) bg_fetch_cycle <= bg_fetch_cycle + 3'd1;
            // New tile row into the shifter
            if (bg_fetch_done && bg_reload_shift) begin
                bg_shift_cnt   <= 4'd8;
                bg_fetch_cycle <= 3'd0;
            end
        end
    end

    // --------------------
    // Registered mode flags and LCD strobe
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            mode3_end_l <= 1'b0;
            mode3_l     <= 1'b0;
            oam_eval_l  <= 1'b0;
            lcd_clkena  <= 1'b0;
        end else if (ce) begin
            mode3_end_l <= pcnt_reset ? 1'b0 : mode3_end;
            mode3_l     <= mode3;
            oam_eval_l  <= oam_eval;
            lcd_clkena  <= lcd_clk;
        end
    end

    // DMG shows mode 0 for one tick between vblank and OAM
    assign mode_vblank = is_gbc ? line.vblank_l : (line.vblank_l && line.vblank_t);

    assign mode = mode_vblank                ? MODE_VBLANK :
                  oam_eval_l                 ? MODE_OAM    :
                  (mode3_l && !mode3_end_l)  ? MODE_DRAW   :
                                               MODE_HBLANK;

    // Palette data is locked while pixels are fetched
    assign drawing = mode3;

endmodule

// ==== hw/video_bypass.sv ====
// Top level of the LCD timing bypass, chaining register, restart, line and pixel stages
`timescale 1ns/1ps

module video_bypass #(
    parameter int LINE_TICKS    = video_bypass_pkg::LINE_TICKS,
    parameter int FRAME_LINES   = video_bypass_pkg::FRAME_LINES,
    parameter int VISIBLE_LINES = video_bypass_pkg::VISIBLE_LINES
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ce,
    input  logic                       ce_cpu,
    input  logic                       is_gbc,
    input  logic                       is_gbc_mode,
    input  logic                       palette_off,
    input  video_bypass_pkg::cpu_bus_t cpu,
    input  logic [1:0]                 mode_real,
    output logic                       lcd_on,
    output logic                       lcd_clkena,
    output logic [14:0]                lcd_data,
    output logic                       lcd_vsync,
    output logic                       overwrite,
    output logic                       vsync_overwrite,
    output logic [1:0]                 mode
);
    import video_bypass_pkg::*;

    lcd_cfg_t    cfg;
    line_state_t line;
    logic [7:0]  pal_lo;
    logic [7:0]  pal_hi;
    logic        restart;
    logic        drawing;

    lcd_regs regs_i (
        .clk(clk), .reset(reset), .ce_cpu(ce_cpu), .is_gbc(is_gbc),
        .is_gbc_mode(is_gbc_mode), .drawing(drawing), .cpu(cpu),
        .cfg(cfg), .pal_lo(pal_lo), .pal_hi(pal_hi)
    );

    lcd_restart restart_i (
        .clk(clk), .reset(reset), .ce(ce), .cfg(cfg), .lcd_vsync(lcd_vsync),
        .mode_real(mode_real), .lcd_on(lcd_on), .restart(restart),
        .overwrite(overwrite), .vsync_overwrite(vsync_overwrite)
    );

    line_timing #(
        .LINE_TICKS(LINE_TICKS), .FRAME_LINES(FRAME_LINES), .VISIBLE_LINES(VISIBLE_LINES)
    ) line_i (
        .clk(clk), .reset(reset), .ce(ce), .is_gbc(is_gbc), .lcd_on(lcd_on),
        .restart(restart), .line(line), .lcd_vsync(lcd_vsync)
    );

    pixel_timing #(.LINE_TICKS(LINE_TICKS)) pixel_i (
        .clk(clk), .reset(reset), .ce(ce), .is_gbc(is_gbc), .lcd_on(lcd_on),
        .restart(restart), .line(line), .scx_fine(cfg.scx_fine), .mode(mode),
        .lcd_clkena(lcd_clkena), .drawing(drawing)
    );

    // White unless DMG palette bypass is selected
    assign lcd_data = (is_gbc_mode || !palette_off) ? 15'h7FFF : {pal_hi[6:0], pal_lo};

endmodule

// ==== tests/video_bypass_checker.sv ====
// Concurrent assertions on restart outputs and mode, bound into the bypass top level
`timescale 1ns/1ps

module video_bypass_checker (
    input logic       clk,
    input logic       reset,
    input logic       ce,
    input logic       overwrite,
    input logic       vsync_overwrite,
    input logic       lcd_clkena,
    input logic [1:0] mode
);

    int   fail_cnt = 0;
    logic was_draw;

    // Mode 3 as seen at the previous ce
    always @(posedge clk) begin
        if (reset) begin
            was_draw <= 1'b0;
        end else if (ce) begin
            was_draw <= (mode == 2'd3);
        end
    end

    // vsync_overwrite is a subset of overwrite
    assert property (@(posedge clk) disable iff (reset) vsync_overwrite |-> overwrite)
        else begin
            fail_cnt++;
            $error("vsync_overwrite high while overwrite is low");
        end

    // Strobe trails mode 3 by at most one ce
    assert property (@(posedge clk) disable iff (reset)
        lcd_clkena |-> (mode == 2'd3 || was_draw))
        else begin
            fail_cnt++;
            $error("lcd_clkena high outside mode 3");
        end

endmodule

bind video_bypass video_bypass_checker checker_i (.*);

// ==== tests/video_bypass_monitor.sv ====
// Testbench monitor that watches the DUT ports, checks frame, pixel and mode rules and keeps counts
`timescale 1ns/1ps

module video_bypass_monitor (
    input logic       clk,
    input logic       reset,
    input logic       ce,
    input logic [1:0] mode,
    input logic       lcd_clkena,
    input logic       lcd_vsync,
    input logic       overwrite
);
    import video_bypass_pkg::*;

    localparam int FRAME_CE = FRAME_LINES * LINE_TICKS * 4;

    int         err_cnt  = 0;
    int         pass_cnt = 0;
    int         test_cnt = 0;
    int         test_err = 0;
    int         frame_ce = 0;
    logic       frame_ok = 1'b0;
    logic       vsync_q  = 1'b0;
    int         pix_cnt  = 0;
    logic       in_line  = 1'b0;
    logic [1:0] mode_q   = 2'd0;

    task automatic check_value(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            err_cnt++;
            test_err++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic report_fail(input string what);
        $display("Failure at %0t: %s", $time, what);
        err_cnt++;
        test_err++;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("Test %0d %s: %s (%0d errors)", test_cnt, name,
                 (test_err == 0) ? "ok" : "bad", test_err);
        test_err = 0;
    endtask

    task automatic summary();
        $display("Tests %0d, checks passed %0d, errors %0d", test_cnt, pass_cnt, err_cnt);
    endtask

    // --------------------
    // Frame period, pixel count per line and mode order
    always @(posedge clk) begin
        if (reset || overwrite) begin
            frame_ok = 1'b0;
            in_line  = 1'b0;
            mode_q   = mode;
        end else begin
            if (ce) frame_ce++;
            if (lcd_vsync && !vsync_q) begin
                if (frame_ok) check_value("frame_ce", frame_ce, FRAME_CE);
                frame_ce = 0;
                frame_ok = 1'b1;
            end
            if (ce && lcd_clkena) begin
                pix_cnt++;
                if (mode == MODE_VBLANK) report_fail("lcd_clkena pulse during vblank");
            end
            if (mode != mode_q) begin
                // Legal steps only, DMG may insert mode 0 after vblank
                if (!((mode_q == MODE_OAM && mode == MODE_DRAW) ||
                      (mode_q == MODE_DRAW && mode == MODE_HBLANK) ||
                      (mode_q == MODE_HBLANK && mode != MODE_DRAW) ||
                      (mode_q == MODE_VBLANK && mode != MODE_DRAW)))
                    report_fail($sformatf("mode stepped from %0d to %0d", mode_q, mode));
                if (mode == MODE_OAM || mode == MODE_VBLANK) begin
                    if (in_line) check_value("lcd_clkena pulses", pix_cnt, 160);
                    in_line = (mode == MODE_OAM);
                    pix_cnt = 0;
                end
            end
            mode_q = mode;
        end
        vsync_q = lcd_vsync;
    end

endmodule

// ==== tests/video_bypass_tb.sv ====
// Testbench top for the LCD timing bypass, runs restart and per-row palette and scroll tests
`timescale 1ns/1ps

module video_bypass_tb;
    import video_bypass_pkg::*;

    localparam int    NUM_ROWS     = 5;
    localparam longint FRAME_CYC   = 70224 * 4;
    localparam longint WATCHDOG_NS = (NUM_ROWS + 2) * 2 * FRAME_CYC * 10 + 100000;

    typedef struct packed {
        logic [2:0]  scx;
        logic [7:0]  p0;
        logic [7:0]  p1;
        logic        gbc_mode;
        logic        pal_off;
        logic [14:0] exp;
    } row_t;

    logic        clk;
    logic        reset;
    logic        ce;
    logic        ce_cpu;
    logic        is_gbc;
    logic        is_gbc_mode;
    logic        palette_off;
    cpu_bus_t    cpu;
    logic [1:0]  mode_real;
    logic        lcd_on;
    logic        lcd_clkena;
    logic [14:0] lcd_data;
    logic        lcd_vsync;
    logic        overwrite;
    logic        vsync_overwrite;
    logic [1:0]  mode;
    logic [1:0]  phase;
    row_t        rows [NUM_ROWS];
    integer      seed;

    video_bypass dut_i (.*);

    video_bypass_monitor mon_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ce every fourth cycle, ce_cpu every second
    initial begin
        phase  = 2'd0;
        ce     = 1'b0;
        ce_cpu = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            phase  = phase + 2'd1;
            ce     = (phase == 2'd0);
            ce_cpu = phase[0];
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Held over two edges, so exactly one sees ce_cpu
    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        cpu.sel_reg = 1'b1;
        cpu.wr      = 1'b1;
        cpu.addr    = addr;
        cpu.data    = data;
        step();
        step();
        cpu = '0;
    endtask

    task automatic wait_mode(input logic [1:0] m);
        longint n;
        n = 0;
        while (mode !== m && n < FRAME_CYC) begin
            step();
            n++;
        end
        if (mode !== m) mon_i.report_fail($sformatf("mode never reached %0d", m));
    endtask

    task automatic wait_vsync_rise();
        longint n;
        n = 0;
        while (lcd_vsync === 1'b1 && n < FRAME_CYC) begin
            step();
            n++;
        end
        while (lcd_vsync !== 1'b1 && n < 2 * FRAME_CYC) begin
            step();
            n++;
        end
        if (lcd_vsync !== 1'b1) mon_i.report_fail("lcd_vsync never rose");
    endtask

    initial begin
        int n;
        row_t r;
        reset       = 1'b1;
        is_gbc      = 1'b1;
        is_gbc_mode = 1'b0;
        palette_off = 1'b1;
        cpu         = '0;
        mode_real   = 2'd0;
        seed        = 32'hfd65;
        rows[0] = '{3'd0, 8'h34, 8'h12, 1'b0, 1'b1, 15'h1234};
        rows[1] = '{3'd3, 8'hA5, 8'h5A, 1'b0, 1'b1, 15'h5AA5};
        rows[2] = '{3'd5, 8'h0F, 8'h7E, 1'b1, 1'b1, 15'h7FFF};
        rows[3] = '{3'd7, 8'hC3, 8'h3C, 1'b0, 1'b0, 15'h7FFF};
        rows[4] = '{3'd2, 8'h6C, 8'h1B, 1'b0, 1'b1, 15'h1B6C};
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        step();

        mon_i.check_value("overwrite", overwrite, 0);
        mon_i.check_value("vsync_overwrite", vsync_overwrite, 0);
        mon_i.check_value("lcd_on", lcd_on, 1);
        mon_i.check_value("lcd_clkena", lcd_clkena, 0);
        mon_i.finish_test("after reset");

        // --------------------
        // LCD enable and restart handshake with the real unit
        write_reg(REG_LCDC, 8'h00);
        write_reg(REG_LCDC, 8'h80);
        if (!overwrite) step();
        mon_i.check_value("overwrite", overwrite, 1);
        wait_vsync_rise();
        for (n = 0; n < 4 && !vsync_overwrite; n++) step();
        mon_i.check_value("vsync_overwrite", vsync_overwrite, 1);
        mode_real = 2'd1;
        step();
        step();
        mode_real = 2'd2;
        // vsync_overwrite drops first, overwrite only once the real unit shows mode 0
        for (n = 0; n < 16 && vsync_overwrite; n++) step();
        mon_i.check_value("vsync_overwrite", vsync_overwrite, 0);
        mon_i.check_value("overwrite", overwrite, 1);
        mode_real = 2'd0;
        for (n = 0; n < 16 && overwrite; n++) step();
        mon_i.check_value("overwrite", overwrite, 0);
        mon_i.finish_test("lcd enable");

        // --------------------
        // Table rows, palette written in vblank, blocked write in mode 3
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = rows[i];
            wait_mode(MODE_VBLANK);
            is_gbc_mode = 1'b1;
            write_reg(REG_SCX, {5'($random(seed)), r.scx});
            write_reg(REG_BGPI, 8'h80);
            write_reg(REG_BGPD, r.p0);
            write_reg(REG_BGPD, r.p1 | (8'($random(seed)) & 8'h80));
            is_gbc_mode = r.gbc_mode;
            palette_off = r.pal_off;
            step();
            mon_i.check_value("lcd_data", lcd_data, r.exp);
            wait_mode(MODE_DRAW);
            is_gbc_mode = 1'b1;
            write_reg(REG_BGPI, 8'h80);
            write_reg(REG_BGPD, ~r.p0);
            is_gbc_mode = r.gbc_mode;
            step();
            mon_i.check_value("lcd_data", lcd_data, r.exp);
            wait_vsync_rise();
            mon_i.finish_test($sformatf("row %0d scx %0d", i, r.scx));
        end

        mon_i.summary();
        if (mon_i.err_cnt == 0 && dut_i.checker_i.fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hw/video_bypass_pkg.sv
hw/lcd_regs.sv
hw/lcd_restart.sv
hw/line_timing.sv
hw/pixel_timing.sv
hw/video_bypass.sv
tests/video_bypass_checker.sv
tests/video_bypass_monitor.sv
tests/video_bypass_tb.sv

// ==== Bender.yml ====
package:
  name: video_bypass

sources:
  - hw/video_bypass_pkg.sv
  - hw/lcd_regs.sv
  - hw/lcd_restart.sv
  - hw/line_timing.sv
  - hw/pixel_timing.sv
  - hw/video_bypass.sv
  - target: test
    files:
      - tests/video_bypass_checker.sv
      - tests/video_bypass_monitor.sv
      - tests/video_bypass_tb.sv
